// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and instruction word width
`define CPU_XLEN 32

// General purpose registers indexed with 4 bits
`define CPU_NREGS 16

// Program counter and instruction memory address width
`define CPU_PCW 8

// Instruction queue entries as any power of two from 2 up
`define CPU_QDEPTH 4

`endif

// ==== src/cpuPkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

    // Opcode field in instr[31:27]
    typedef enum logic [4:0] {
        ADD  = 5'b00011,
        SUB  = 5'b00100,
        AND  = 5'b00101,
        OR   = 5'b00110,
        ADDI = 5'b01100,
        BR   = 5'b10010,
        OUT  = 5'b10110,
        NOP  = 5'b11001,
        HALT = 5'b11010
    } opcodeT;

    // Branch condition in instr[20:19] of a BR word
    typedef enum logic [1:0] {
        ZR = 2'b00, // Zero
        NZ = 2'b01, // Nonzero
        PL = 2'b10, // Sign clear
        MI = 2'b11  // Sign set
    } brCondT;

    // Word as it travels from fetch to execute
    typedef struct packed {
        logic [`CPU_XLEN-1:0] instr;
        logic [`CPU_PCW-1:0]  pc;    // Address the word was read from
        logic                 epoch; // Fetch epoch at read time
    } fetchWordT;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

`include "cpu_defines.svh"

module regFile (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] raddrA,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] raddrB,
    input  wire logic                          we,
    input  wire logic [$clog2(`CPU_NREGS)-1:0] waddr,
    input  wire logic [`CPU_XLEN-1:0]          wdata,
    output logic      [`CPU_XLEN-1:0]          rdataA,
    output logic      [`CPU_XLEN-1:0]          rdataB
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // Asynchronous read ports
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/branchCond.sv ====
`default_nettype none

`include "cpu_defines.svh"

module branchCond (
    input  cpuPkg::brCondT            cond,
    input  wire logic [`CPU_XLEN-1:0] value,
    output logic                      taken
);

    logic isZero;
    logic isNeg;

    assign isZero = (value == '0);
    assign isNeg  = value[`CPU_XLEN-1]; // Sign bit

    // CON evaluation
    always_comb begin
        case (cond)
            cpuPkg::ZR: taken = isZero;
            cpuPkg::NZ: taken = !isZero;
            cpuPkg::PL: taken = !isNeg;
            cpuPkg::MI: taken = isNeg;
            default:    taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`default_nettype none

`include "cpu_defines.svh"

module fetchUnit (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic [`CPU_XLEN-1:0] imemData,
    input  wire logic                 inAck,
    input  wire logic                 redirect,
    input  wire logic [`CPU_PCW-1:0]  redirectPc,
    input  wire logic                 halted,
    output logic      [`CPU_PCW-1:0]  imemAddr,
    output logic                      inReq,
    output cpuPkg::fetchWordT         inData
);

    logic [`CPU_PCW-1:0] pc;
    logic                epoch;
    logic                issue;

    // Memory answers in the same cycle
    assign imemAddr = pc;

    // Start a new transfer only once the last ack has fallen
    assign issue = !inReq && !inAck && !halted && !redirect;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc    <= '0;
            epoch <= 1'b0;
            inReq <= 1'b0;
        end else begin
            if (redirect) begin
                // Open handshake still finishes with the old epoch
                pc    <= redirectPc;
                epoch <= ~epoch;
            end else if (issue) begin
                pc <= pc + `CPU_PCW'(1);
            end

            if (issue) begin
                inReq <= 1'b1;
            end else if (inReq && inAck) begin
                inReq <= 1'b0; // Second phase
            end
        end
    end

    // Word is held stable for the whole request
    always_ff @(posedge clk) begin
        if (issue) begin
            inData.instr <= imemData;
            inData.pc    <= pc;
            inData.epoch <= epoch;
        end
    end

endmodule

`default_nettype wire

// ==== src/instrQueue.sv ====
`default_nettype none

module instrQueue #(
    parameter type payloadT = logic,
    parameter int  depth    = 4
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic inReq,
    input  payloadT   inData,
    output logic      inAck,
    output logic      outReq,
    input  wire logic outAck,
    output payloadT   outData
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

    payloadT mem [depth];

    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   count;
    logic            full;
    logic            empty;
    logic            push;
    logic            pop;

    assign full  = (count == (ptrW + 1)'(depth));
    assign empty = (count == '0);

    // New request not yet acked and room to store it
    assign push = inReq && !inAck && !full;
    // Consumer acked, so outReq falls and the head leaves
    assign pop = outReq && outAck;

    assign outData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            inAck  <= 1'b0;
            outReq <= 1'b0;
        end else begin
            // Input side acts as a four-phase consumer
            if (push) begin
                inAck <= 1'b1;
                wrPtr <= wrPtr + ptrW'(1);
            end else if (inAck && !inReq) begin
                inAck <= 1'b0;
            end

            // Output side acts as a four-phase producer
            if (pop) begin
                outReq <= 1'b0;
                rdPtr  <= rdPtr + ptrW'(1);
            end else if (!outReq && !outAck && !empty) begin
                outReq <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + (ptrW + 1)'(1);
                2'b01:   count <= count - (ptrW + 1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`default_nettype none

`include "cpu_defines.svh"

module execUnit (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic                          outReq,
    input  cpuPkg::fetchWordT                  outData,
    output logic                               outAck,
    output logic                               redirect,
    output logic      [`CPU_PCW-1:0]           redirectPc,
    output logic                               wbValid,
    output logic      [$clog2(`CPU_NREGS)-1:0] wbReg,
    output logic      [`CPU_XLEN-1:0]          wbData,
    output logic                               outValid,
    output logic      [`CPU_XLEN-1:0]          outPortData,
    output logic                               halted
);

    localparam int ridxW = $clog2(`CPU_NREGS);

    cpuPkg::fetchWordT curWord;
    cpuPkg::opcodeT    op;
    cpuPkg::brCondT    cond;

    logic                 curValid;
    logic                 expEpoch;
    logic                 live;
    logic                 capture;
    logic                 isAlu;
    logic                 brTaken;
    logic [ridxW-1:0]     ra;
    logic [ridxW-1:0]     rb;
    logic [ridxW-1:0]     rc;
    logic [ridxW-1:0]     rdAddrA;
    logic [`CPU_XLEN-1:0] cImm;
    logic [`CPU_XLEN-1:0] opA;
    logic [`CPU_XLEN-1:0] opB;
    logic [`CPU_XLEN-1:0] aluRes;

    // Field decode
    assign op   = cpuPkg::opcodeT'(curWord.instr[31:27]);
    assign ra   = curWord.instr[26:23];
    assign rb   = curWord.instr[22:19];
    assign rc   = curWord.instr[18:15];
    assign cond = cpuPkg::brCondT'(curWord.instr[20:19]);
    assign cImm = {{(`CPU_XLEN - 19){curWord.instr[18]}}, curWord.instr[18:0]};

    // Wrong-path words from an older epoch are dropped here
    assign live    = curValid && (curWord.epoch == expEpoch);
    assign capture = outReq && !outAck && !halted;

    // BR and OUT read Ra on port A
    assign rdAddrA = (op == cpuPkg::BR || op == cpuPkg::OUT) ? ra : rb;

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (rdAddrA),
        .raddrB (rc),
        .we     (live && isAlu),
        .waddr  (ra),
        .wdata  (aluRes),
        .rdataA (opA),
        .rdataB (opB)
    );

    branchCond uBranchCond (
        .cond  (cond),
        .value (opA),
        .taken (brTaken)
    );

    always_comb begin
        isAlu  = 1'b1;
        aluRes = '0;
        case (op)
            cpuPkg::ADD:  aluRes = opA + opB;
            cpuPkg::SUB:  aluRes = opA - opB;
            cpuPkg::AND:  aluRes = opA & opB;
            cpuPkg::OR:   aluRes = opA | opB;
            cpuPkg::ADDI: aluRes = opA + cImm;
            default:      isAlu  = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outAck   <= 1'b0;
            curValid <= 1'b0;
            expEpoch <= 1'b0;
            wbValid  <= 1'b0;
            outValid <= 1'b0;
            redirect <= 1'b0;
            halted   <= 1'b0;
        end else begin
            // Result pulses land one cycle after the ack rise
            wbValid  <= live && isAlu;
            outValid <= live && (op == cpuPkg::OUT);
            redirect <= live && (op == cpuPkg::BR) && brTaken;
            if (live && op == cpuPkg::HALT) begin
                halted <= 1'b1;
            end
            if (live && op == cpuPkg::BR && brTaken) begin
                expEpoch <= ~expEpoch;
            end

            curValid <= capture;
            if (capture) begin
                outAck <= 1'b1;
            end else if (outAck && !outReq) begin
                outAck <= 1'b0; // Four-phase return to idle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            curWord <= outData;
        end
        if (live) begin
            wbReg       <= ra;
            wbData      <= aluRes;
            outPortData <= opA;
            redirectPc  <= curWord.pc + `CPU_PCW'(1) + cImm[`CPU_PCW-1:0]; // PC+1+C
        end
    end

endmodule

`default_nettype wire

// ==== src/busCpuTop.sv ====
`default_nettype none

`include "cpu_defines.svh"

module busCpuTop (
    input  wire logic                          clk,
    input  wire logic                          rstN,
    input  wire logic [`CPU_XLEN-1:0]          imemData,
    output logic      [`CPU_PCW-1:0]           imemAddr,
    output logic                               wbValid,
    output logic      [$clog2(`CPU_NREGS)-1:0] wbReg,
    output logic      [`CPU_XLEN-1:0]          wbData,
    output logic                               outValid,
    output logic      [`CPU_XLEN-1:0]          outPortData,
    output logic                               halted
);

    // Fetch side of the queue
    logic              inReq;
    logic              inAck;
    cpuPkg::fetchWordT inData;

    // Execute side of the queue
    logic              outReq;
    logic              outAck;
    cpuPkg::fetchWordT outData;

    logic                redirect;
    logic [`CPU_PCW-1:0] redirectPc;

    fetchUnit uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .imemData   (imemData),
        .inAck      (inAck),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .halted     (halted),
        .imemAddr   (imemAddr),
        .inReq      (inReq),
        .inData     (inData)
    );

    instrQueue #(
        .payloadT (cpuPkg::fetchWordT),
        .depth    (`CPU_QDEPTH)
    ) uQueue (
        .clk     (clk),
        .rstN    (rstN),
        .inReq   (inReq),
        .inData  (inData),
        .inAck   (inAck),
        .outReq  (outReq),
        .outAck  (outAck),
        .outData (outData)
    );

    execUnit uExec (
        .clk         (clk),
        .rstN        (rstN),
        .outReq      (outReq),
        .outData     (outData),
        .outAck      (outAck),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .outValid    (outValid),
        .outPortData (outPortData),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// ==== dv/busCpuTb.sv ====
`default_nettype none

`include "cpu_defines.svh"

module busCpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int romWords    = 1 << `CPU_PCW;
    localparam int recBase     = romWords;     // Records follow the ROM image
    localparam int patWords    = 2 * romWords;
    localparam int resetCycles = 16;
    localparam int haltWatch   = 50;
    localparam int numTests    = 5;

    localparam logic [3:0] kindWb  = 4'h1;
    localparam logic [3:0] kindOut = 4'h2;

    logic                          clk;
    logic                          rstN;
    logic [`CPU_XLEN-1:0]          imemData;
    logic [`CPU_PCW-1:0]           imemAddr;
    logic                          wbValid;
    logic [$clog2(`CPU_NREGS)-1:0] wbReg;
    logic [`CPU_XLEN-1:0]          wbData;
    logic                          outValid;
    logic [`CPU_XLEN-1:0]          outPortData;
    logic                          halted;

    // Record layout is test id, kind, register, value
    logic [43:0] patMem [patWords];

    int recIdx;
    int recCount;
    int cycleLimit;
    bit patternsLoaded;
    int testChecks [1:numTests];
    int testErrs   [1:numTests];
    bit testDone   [1:numTests];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Instruction ROM answers in the same cycle
    assign imemData = patMem[imemAddr][`CPU_XLEN-1:0];

    busCpuTop uut (
        .clk         (clk),
        .rstN        (rstN),
        .imemData    (imemData),
        .imemAddr    (imemAddr),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .outValid    (outValid),
        .outPortData (outPortData),
        .halted      (halted)
    );

    function automatic string testTitle(input int tid);
        case (tid)
            1:       return "reset";
            2:       return "ALU writebacks";
            3:       return "not-taken branches";
            4:       return "brnz taken";
            5:       return "out and halt";
            default: return "unknown";
        endcase
    endfunction

    function automatic string kindName(input logic [3:0] kind);
        return (kind == kindWb) ? "writeback" : "out";
    endfunction

    task automatic loadPatterns();
        int executed;
        // NOP fill carries the address in its low bits and leaves kind 0 for records
        for (int i = 0; i < patWords; i++) begin
            patMem[i] = {12'h000, cpuPkg::NOP, 18'h0, 9'(i)};
        end
        $readmemh("dv/cpu_patterns.txt", patMem);
        executed = romWords;
        for (int i = romWords - 1; i >= 0; i--) begin
            if (patMem[i][31:27] == cpuPkg::HALT) begin
                executed = i + 1; // Straight-line run up to the first HALT
            end
        end
        recCount = 0;
        while (recBase + recCount < patWords &&
               patMem[recBase + recCount][39:36] != 4'h0) begin
            recCount++;
        end
        cycleLimit = 16 * executed + 200;
        $display("loaded %0d expected records, cycle limit %0d", recCount, cycleLimit);
    endtask

    task automatic reportTest(input int tid);
        testDone[tid] = 1'b1;
        $display("test %0d (%s): %0d checks, %0d errors, %s", tid, testTitle(tid),
                 testChecks[tid], testErrs[tid], (testErrs[tid] == 0) ? "pass" : "fail");
    endtask

    task automatic expectLow(input string name, input logic value, input string phase);
        testChecks[1]++;
        if (value !== 1'b0) begin
            $display("MISMATCH %s %s: expected 0x0, got 0x%h", name, phase, value);
            testErrs[1]++;
        end
    endtask

    task automatic checkIdle(input string phase);
        expectLow("wbValid", wbValid, phase);
        expectLow("outValid", outValid, phase);
        expectLow("halted", halted, phase);
    endtask

    // Compare one result pulse with the next expected record
    task automatic checkPulse(input logic [3:0] kind, input logic [3:0] regIdx,
                              input logic [`CPU_XLEN-1:0] value);
        logic [43:0] rec;
        int          tid;
        string       valName;
        if (recIdx >= recCount) begin
            $display("ERROR: unexpected %s pulse with value 0x%08h, no records left",
                     kindName(kind), value);
            testErrs[numTests]++;
            return;
        end
        rec     = patMem[recBase + recIdx];
        tid     = int'(rec[43:40]);
        valName = (kind == kindWb) ? "wbData" : "outPortData";
        testChecks[tid]++;
        if (rec[39:36] != kind) begin
            $display("ERROR: record %0d expects a %s pulse but a %s pulse arrived",
                     recIdx, kindName(rec[39:36]), kindName(kind));
            testErrs[tid]++;
        end else begin
            if (kind == kindWb && rec[35:32] !== regIdx) begin
                $display("MISMATCH wbReg: expected 0x%h, got 0x%h", rec[35:32], regIdx);
                testErrs[tid]++;
            end
            if (rec[31:0] !== value) begin
                $display("MISMATCH %s: expected 0x%08h, got 0x%08h", valName, rec[31:0], value);
                testErrs[tid]++;
            end
        end
        recIdx++;
        // Last group stays open for the halt checks
        if (recIdx < recCount && int'(patMem[recBase + recIdx][43:40]) != tid) begin
            reportTest(tid);
        end
    endtask

    // Results are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (halted === 1'b1 && (wbValid === 1'b1 || outValid === 1'b1)) begin
                $display("ERROR: result pulse seen after halted rose");
                testErrs[numTests]++;
            end else begin
                if (wbValid === 1'b1) begin
                    checkPulse(kindWb, wbReg, wbData);
                end
                if (outValid === 1'b1) begin
                    checkPulse(kindOut, 4'h0, outPortData);
                end
            end
        end
    end

    initial begin : timeoutWatch
        int cycles;
        cycles = 0;
        wait (patternsLoaded && rstN === 1'b1);
        while (halted !== 1'b1 && cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("ERROR: halted never rose within %0d cycles after reset", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin : mainSeq
        int totalChecks;
        int totalErrs;
        rstN   = 1'b0;
        recIdx = 0;
        loadPatterns();
        patternsLoaded = 1'b1;

        for (int c = 0; c < resetCycles; c++) begin
            @(negedge clk);
            checkIdle("during reset");
        end
        @(posedge clk);
        rstN <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            checkIdle("after reset");
        end
        reportTest(1);

        // Program runs on its own from here
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (haltWatch) begin
            @(negedge clk);
        end
        testChecks[numTests]++;
        if (halted !== 1'b1) begin
            $display("MISMATCH halted: expected 0x1, got 0x%h", halted);
            testErrs[numTests]++;
        end
        testChecks[numTests]++;
        if (recIdx != recCount) begin
            $display("ERROR: %0d of %0d expected records never arrived",
                     recCount - recIdx, recCount);
            testErrs[numTests]++;
        end

        totalChecks = 0;
        totalErrs   = 0;
        for (int t = 1; t <= numTests; t++) begin
            if (!testDone[t]) begin
                reportTest(t);
            end
            totalChecks += testChecks[t];
            totalErrs   += testErrs[t];
        end
        $display("tests %0d, checks %0d, errors %0d", numTests, totalChecks, totalErrs);
        if (totalErrs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpu_patterns.txt ====
// ROM from @000, one 32-bit instruction per line, unlisted words are NOP fill
// Records from @100: test id, kind (1 writeback, 2 out), register, 32-bit value
@000
60800005 // addi r1 = r0 + 5
61000003 // addi r2 = r0 + 3
19890000 // add  r3 = r1 + r2
22108000 // sub  r4 = r2 - r1
2A8A0000 // and  r5 = r1 & r4
33090000 // or   r6 = r1 | r2
6387FFFF // addi r7 = r0 - 1
90800001 // brzr r1, +1
64180002 // addi r8 = r3 + 2
92100001 // brpl r4, +1
64C00001 // addi r9 = r8 + 1
91980001 // brmi r3, +1
65480001 // addi r10 = r9 + 1
90880003 // brnz r1, +3 to 0x11
65800111 // addi r11 = r0 + 0x111, wrong path
B0800000 // out r1, wrong path
18888000 // add r1 = r1 + r1, wrong path
66080020 // addi r12 = r1 + 0x20
B2000000 // out r4
C8000000 // nop
B6000000 // out r12
D0000000 // halt
66800077 // addi r13 = r0 + 0x77, never runs
B6800000 // out r13, never runs
1F6E8000 // add r14 = r13 + r13, never runs
@100
21100000005
21200000003
21300000008
214FFFFFFFE
21500000004
21600000007
217FFFFFFFF
3180000000A
3190000000B
31A0000000C
41C00000025
524FFFFFFFE
52C00000025
00000000000 // end of records

// ==== files.f ====
+incdir+include
src/cpuPkg.sv
src/regFile.sv
src/branchCond.sv
src/fetchUnit.sv
src/instrQueue.sv
src/execUnit.sv
src/busCpuTop.sv
dv/busCpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the busCpuTb simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
rm -f "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --timescale 1ns/100ps \
    -f files.f --top-module busCpuTb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VbusCpuTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    exit 1
fi

exit 0
